/* Makefile */
RTL = island_pkg.sv island_req_buffer.sv island_router.sv island_sram_bank.sv \
      island_soc_ctrl.sv island_top.sv

.PHONY: all run lint clean

all: run

obj_dir/Vtb_island_top: sources.f $(wildcard *.sv) island_defines.svh
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_island_top

run: obj_dir/Vtb_island_top
	./obj_dir/Vtb_island_top | tee sim.log
	@! grep -q "SIMULATION FAILED" sim.log
	@grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only -Wall +incdir+. $(RTL) --top-module island_top
	verilator --lint-only -Wall --timing -f sources.f --top-module tb_island_top

clean:
	rm -rf obj_dir sim.log

/* island_asserts.sv */
// ----------------------------------------------------------
// Router flow-control assertions, bound into island_router.
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "island_defines.svh"
`default_nettype none

module island_asserts (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic                                  head_valid_i,
  input logic                                  pop_o,
  input logic                                  rsp_valid_o,
  input logic                                  rsp_credit_i,
  input logic [$clog2(`ISL_RSP_CREDITS+1)-1:0] credits_q
);

  localparam int unsigned CrdW = $clog2(`ISL_RSP_CREDITS + 1);
  localparam int unsigned UnpW = CrdW + 1;

  // Responses seen on the port and not yet paid back by the manager
  logic [UnpW-1:0] unpaid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_unpaid
    if (!rst_ni) begin
      unpaid_q <= '0;
    end else begin
      unpaid_q <= unpaid_q + UnpW'(rsp_valid_o) - UnpW'(rsp_credit_i);
    end
  end

  rsp_needs_credit: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> (unpaid_q < UnpW'(`ISL_RSP_CREDITS))
  ) else $error("response produced without a response credit held");

  credits_bounded: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    credits_q <= CrdW'(`ISL_RSP_CREDITS)
  ) else $error("response credit counter above its start value");

  head_held: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    head_valid_i && !pop_o |=> head_valid_i
  ) else $error("buffer head dropped before it was popped");

endmodule

bind island_router island_asserts i_asserts (
  .clk_i,
  .rst_ni,
  .head_valid_i,
  .pop_o,
  .rsp_valid_o,
  .rsp_credit_i,
  .credits_q
);

`default_nettype wire

/* island_defines.svh */
// ----------------------------------------------------------
// Widths, depths, credits and address map of the island.
// Include this header wherever one of these values is needed.
// ----------------------------------------------------------
`ifndef ISLAND_DEFINES_SVH
`define ISLAND_DEFINES_SVH

// Datapath
`define ISL_ADDR_WIDTH        16
`define ISL_DATA_WIDTH        32
`define ISL_BE_WIDTH          4

// Memory banks, contiguous from the base
`define ISL_NUM_BANKS         2
`define ISL_BANK_BYTES        1024
`define ISL_BANK_BASE         16'h0000

// SoC control window and its registers
`define ISL_CTRL_BASE         16'h2000
`define ISL_CTRL_BYTES        16
`define ISL_REG_BOOTADDR      16'h0000
`define ISL_REG_FETCHEN       16'h0004
`define ISL_REG_BOOTMODE      16'h0008
`define ISL_BOOT_ADDR_DEFAULT 32'h0000_2080

// Flow control
`define ISL_REQ_DEPTH         4
`define ISL_RSP_CREDITS       4

`define ISL_ERR_RDATA         32'hBADC_AB1E

`endif

/* island_pkg.sv */
// ----------------------------------------------------------
// Shared types of the island: opcodes, boot modes, targets.
// ----------------------------------------------------------
`default_nettype none

package island_pkg;

  // Request opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } island_op_e;

  // Boot mode pin encoding
  typedef enum logic [1:0] {
    BOOT_PRELOAD = 2'd0,
    BOOT_JTAG    = 2'd1,
    BOOT_SPI     = 2'd2,
    BOOT_UART    = 2'd3
  } boot_mode_e;

  // Router destination after address decode
  typedef enum logic [1:0] {
    TGT_BANK = 2'd0,
    TGT_CTRL = 2'd1,
    TGT_ERR  = 2'd2
  } island_target_e;

endpackage

`default_nettype wire

/* island_req_buffer.sv */
// ----------------------------------------------------------
// Credit-controlled request FIFO; one credit returns per pop.
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "island_defines.svh"
`default_nettype none

module island_req_buffer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_valid_i,
  input  island_pkg::island_op_e     req_op_i,
  input  logic [`ISL_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [`ISL_DATA_WIDTH-1:0] req_wdata_i,
  input  logic [`ISL_BE_WIDTH-1:0]   req_be_i,
  output logic                       head_valid_o,
  output island_pkg::island_op_e     head_op_o,
  output logic [`ISL_ADDR_WIDTH-1:0] head_addr_o,
  output logic [`ISL_DATA_WIDTH-1:0] head_wdata_o,
  output logic [`ISL_BE_WIDTH-1:0]   head_be_o,
  input  logic                       pop_i,
  output logic                       req_credit_o
);
  import island_pkg::*;

  localparam int unsigned PtrW = (`ISL_REQ_DEPTH > 1) ? $clog2(`ISL_REQ_DEPTH) : 1;
  localparam int unsigned CntW = $clog2(`ISL_REQ_DEPTH + 1);

  island_op_e                 op_mem    [`ISL_REQ_DEPTH];
  logic [`ISL_ADDR_WIDTH-1:0] addr_mem  [`ISL_REQ_DEPTH];
  logic [`ISL_DATA_WIDTH-1:0] wdata_mem [`ISL_REQ_DEPTH];
  logic [`ISL_BE_WIDTH-1:0]   be_mem    [`ISL_REQ_DEPTH];
  logic [PtrW-1:0]            wr_ptr_q;
  logic [PtrW-1:0]            rd_ptr_q;
  logic [CntW-1:0]            count_q;
  logic                       do_pop;

  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(`ISL_REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_valid_o = (count_q != '0);
  assign do_pop       = pop_i & head_valid_o;
  // Credit goes back in the pop cycle itself
  assign req_credit_o = do_pop;

  assign head_op_o    = op_mem[rd_ptr_q];
  assign head_addr_o  = addr_mem[rd_ptr_q];
  assign head_wdata_o = wdata_mem[rd_ptr_q];
  assign head_be_o    = be_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin : proc_store
    if (req_valid_i) begin
      op_mem[wr_ptr_q]    <= req_op_i;
      addr_mem[wr_ptr_q]  <= req_addr_i;
      wdata_mem[wr_ptr_q] <= req_wdata_i;
      be_mem[wr_ptr_q]    <= req_be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ptrs
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      count_q <= count_q + CntW'(req_valid_i) - CntW'(do_pop);
    end
  end

endmodule

`default_nettype wire

/* island_router.sv */
// ----------------------------------------------------------
// Address decode, dispatch under response credits, in-order
// response mux and the built-in error responder.
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "island_defines.svh"
`default_nettype none

module island_router (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           head_valid_i,
  input  island_pkg::island_op_e                         head_op_i,
  input  logic [`ISL_ADDR_WIDTH-1:0]                     head_addr_i,
  input  logic [`ISL_DATA_WIDTH-1:0]                     head_wdata_i,
  input  logic [`ISL_BE_WIDTH-1:0]                       head_be_i,
  output logic                                           pop_o,
  output logic [`ISL_NUM_BANKS-1:0]                      bank_req_o,
  output logic                                           ctrl_req_o,
  output island_pkg::island_op_e                         tgt_op_o,
  output logic [`ISL_ADDR_WIDTH-1:0]                     tgt_addr_o,
  output logic [`ISL_DATA_WIDTH-1:0]                     tgt_wdata_o,
  output logic [`ISL_BE_WIDTH-1:0]                       tgt_be_o,
  input  logic [`ISL_NUM_BANKS-1:0][`ISL_DATA_WIDTH-1:0] bank_rdata_i,
  input  logic [`ISL_DATA_WIDTH-1:0]                     ctrl_rdata_i,
  output logic                                           rsp_valid_o,
  output logic [`ISL_DATA_WIDTH-1:0]                     rsp_rdata_o,
  output logic                                           rsp_err_o,
  input  logic                                           rsp_credit_i
);
  import island_pkg::*;

  localparam int unsigned AddrW    = `ISL_ADDR_WIDTH;
  localparam int unsigned BankIdxW = (`ISL_NUM_BANKS > 1) ? $clog2(`ISL_NUM_BANKS) : 1;
  localparam int unsigned CrdW     = $clog2(`ISL_RSP_CREDITS + 1);
  localparam logic [AddrW-1:0] BankSpan  = AddrW'(`ISL_NUM_BANKS * `ISL_BANK_BYTES);
  localparam logic [AddrW-1:0] BankBytes = AddrW'(`ISL_BANK_BYTES);
  localparam logic [AddrW-1:0] CtrlBytes = AddrW'(`ISL_CTRL_BYTES);

  island_target_e      tgt;
  logic [BankIdxW-1:0] bank_idx;
  logic [AddrW-1:0]    bank_off;
  logic [AddrW-1:0]    ctrl_off;
  logic                dispatch;
  logic [CrdW-1:0]     credits_q;
  logic                rsp_valid_q;
  island_target_e      rec_tgt_q;
  logic [BankIdxW-1:0] rec_bank_q;
  island_op_e          rec_op_q;

  // ----------------------------------------------------------
  // Decode and dispatch
  // ----------------------------------------------------------
  assign bank_off = head_addr_i - `ISL_BANK_BASE;
  assign ctrl_off = head_addr_i - `ISL_CTRL_BASE;

  // Offsets wrap below the base, so one unsigned compare per window
  always_comb begin : proc_decode
    tgt        = TGT_ERR;
    bank_idx   = '0;
    tgt_addr_o = head_addr_i;
    if (bank_off < BankSpan) begin
      tgt        = TGT_BANK;
      bank_idx   = BankIdxW'(bank_off / BankBytes);
      tgt_addr_o = bank_off % BankBytes;
    end else if (ctrl_off < CtrlBytes) begin
      tgt        = TGT_CTRL;
      tgt_addr_o = ctrl_off;
    end
  end

  assign dispatch    = head_valid_i && (credits_q != '0);
  assign pop_o       = dispatch;
  assign ctrl_req_o  = dispatch && (tgt == TGT_CTRL);
  assign tgt_op_o    = head_op_i;
  assign tgt_wdata_o = head_wdata_i;
  assign tgt_be_o    = head_be_i;

  always_comb begin : proc_bank_req
    for (int i = 0; i < `ISL_NUM_BANKS; i++) begin
      bank_req_o[i] = dispatch && (tgt == TGT_BANK) && (bank_idx == BankIdxW'(i));
    end
  end

  // ----------------------------------------------------------
  // Credits and response record
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_credits
    if (!rst_ni) begin
      credits_q <= CrdW'(`ISL_RSP_CREDITS);
    end else begin
      credits_q <= credits_q + CrdW'(rsp_credit_i) - CrdW'(dispatch);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_record
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      rec_tgt_q   <= TGT_BANK;
      rec_bank_q  <= '0;
      rec_op_q    <= OP_READ;
    end else begin
      rsp_valid_q <= dispatch;
      if (dispatch) begin
        rec_tgt_q  <= tgt;
        rec_bank_q <= bank_idx;
        rec_op_q   <= head_op_i;
      end
    end
  end

  // Targets answer one cycle after their strobe
  always_comb begin : proc_rsp_mux
    case (rec_tgt_q)
      TGT_BANK: rsp_rdata_o = bank_rdata_i[rec_bank_q];
      TGT_CTRL: rsp_rdata_o = ctrl_rdata_i;
      default:  rsp_rdata_o = `ISL_ERR_RDATA;
    endcase
    if (rec_op_q == OP_WRITE) begin
      rsp_rdata_o = '0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = (rec_tgt_q == TGT_ERR);

endmodule

`default_nettype wire

/* island_soc_ctrl.sv */
// ----------------------------------------------------------
// SoC control registers: boot address, fetch enable and the
// boot mode captured on the first cycle out of reset.
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "island_defines.svh"
`default_nettype none

module island_soc_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  island_pkg::island_op_e     op_i,
  input  logic [`ISL_ADDR_WIDTH-1:0] addr_i,
  input  logic [`ISL_DATA_WIDTH-1:0] wdata_i,
  output logic [`ISL_DATA_WIDTH-1:0] rdata_o,
  input  island_pkg::boot_mode_e     bootmode_i,
  input  logic                       fetch_enable_i,
  output logic                       fetch_enable_o,
  output logic [`ISL_DATA_WIDTH-1:0] boot_addr_o
);
  import island_pkg::*;

  localparam int unsigned DataW = `ISL_DATA_WIDTH;

  logic                 first_cycle_q;
  logic [DataW-1:0]     bootaddr_q;
  logic                 fetchen_q;
  boot_mode_e           bootmode_q;
  logic [DataW-1:0]     rdata_d;
  logic [DataW-1:0]     rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_first_cycle
    if (!rst_ni) begin
      first_cycle_q <= 1'b1;
    end else begin
      first_cycle_q <= 1'b0;
    end
  end

  // Hardware capture takes priority over a bus write
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_regs
    if (!rst_ni) begin
      bootaddr_q <= `ISL_BOOT_ADDR_DEFAULT;
      fetchen_q  <= 1'b0;
      bootmode_q <= BOOT_PRELOAD;
    end else if (first_cycle_q) begin
      bootmode_q <= bootmode_i;
      fetchen_q  <= (bootmode_i == BOOT_JTAG);
    end else if (req_i && (op_i == OP_WRITE)) begin
      case (addr_i)
        `ISL_REG_BOOTADDR: bootaddr_q <= wdata_i;
        `ISL_REG_FETCHEN:  fetchen_q  <= wdata_i[0];
        default: ;
      endcase
    end
  end

  // Bootmode is read-only, unknown offsets read zero
  always_comb begin : proc_read_mux
    case (addr_i)
      `ISL_REG_BOOTADDR: rdata_d = bootaddr_q;
      `ISL_REG_FETCHEN:  rdata_d = DataW'(fetchen_q);
      `ISL_REG_BOOTMODE: rdata_d = DataW'(bootmode_q);
      default:           rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rdata
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && (op_i == OP_READ)) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o        = rdata_q;
  assign fetch_enable_o = fetchen_q | fetch_enable_i;
  assign boot_addr_o    = bootaddr_q;

endmodule

`default_nettype wire

/* island_sram_bank.sv */
// ----------------------------------------------------------
// Word-addressed SRAM bank with byte enables.
// Read data is registered and valid one cycle after req_i.
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "island_defines.svh"
`default_nettype none

module island_sram_bank (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_i,
  input  island_pkg::island_op_e                op_i,
  input  logic [$clog2(`ISL_BANK_BYTES/4)-1:0]  addr_i,
  input  logic [`ISL_DATA_WIDTH-1:0]            wdata_i,
  input  logic [`ISL_BE_WIDTH-1:0]              be_i,
  output logic [`ISL_DATA_WIDTH-1:0]            rdata_o
);
  import island_pkg::*;

  localparam int unsigned NumWords = `ISL_BANK_BYTES / 4;

  logic [`ISL_DATA_WIDTH-1:0] mem [NumWords];
  logic [`ISL_DATA_WIDTH-1:0] rdata_q;

  always_ff @(posedge clk_i) begin : proc_write
    if (req_i && (op_i == OP_WRITE)) begin
      for (int b = 0; b < `ISL_BE_WIDTH; b++) begin
        if (be_i[b]) begin
          mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_read
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && (op_i == OP_READ)) begin
      rdata_q <= mem[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* island_top.sv */
// ----------------------------------------------------------
// Island top: request buffer, router, SRAM banks, SoC control.
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "island_defines.svh"
`default_nettype none

module island_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_valid_i,
  input  island_pkg::island_op_e     req_op_i,
  input  logic [`ISL_ADDR_WIDTH-1:0] req_addr_i,
  input  logic [`ISL_DATA_WIDTH-1:0] req_wdata_i,
  input  logic [`ISL_BE_WIDTH-1:0]   req_be_i,
  output logic                       req_credit_o,
  output logic                       rsp_valid_o,
  output logic [`ISL_DATA_WIDTH-1:0] rsp_rdata_o,
  output logic                       rsp_err_o,
  input  logic                       rsp_credit_i,
  input  island_pkg::boot_mode_e     bootmode_i,
  input  logic                       fetch_enable_i,
  output logic                       fetch_enable_o,
  output logic [`ISL_DATA_WIDTH-1:0] boot_addr_o
);
  import island_pkg::*;

  localparam int unsigned WordAw = $clog2(`ISL_BANK_BYTES / 4);

  logic                                           head_valid;
  island_op_e                                     head_op;
  logic [`ISL_ADDR_WIDTH-1:0]                     head_addr;
  logic [`ISL_DATA_WIDTH-1:0]                     head_wdata;
  logic [`ISL_BE_WIDTH-1:0]                       head_be;
  logic                                           pop;
  logic [`ISL_NUM_BANKS-1:0]                      bank_req;
  logic                                           ctrl_req;
  island_op_e                                     tgt_op;
  logic [`ISL_ADDR_WIDTH-1:0]                     tgt_addr;
  logic [`ISL_DATA_WIDTH-1:0]                     tgt_wdata;
  logic [`ISL_BE_WIDTH-1:0]                       tgt_be;
  logic [`ISL_NUM_BANKS-1:0][`ISL_DATA_WIDTH-1:0] bank_rdata;
  logic [`ISL_DATA_WIDTH-1:0]                     ctrl_rdata;

  island_req_buffer i_req_buffer (
    .clk_i,
    .rst_ni,
    .req_valid_i,
    .req_op_i,
    .req_addr_i,
    .req_wdata_i,
    .req_be_i,
    .head_valid_o ( head_valid ),
    .head_op_o    ( head_op    ),
    .head_addr_o  ( head_addr  ),
    .head_wdata_o ( head_wdata ),
    .head_be_o    ( head_be    ),
    .pop_i        ( pop        ),
    .req_credit_o
  );

  island_router i_router (
    .clk_i,
    .rst_ni,
    .head_valid_i ( head_valid ),
    .head_op_i    ( head_op    ),
    .head_addr_i  ( head_addr  ),
    .head_wdata_i ( head_wdata ),
    .head_be_i    ( head_be    ),
    .pop_o        ( pop        ),
    .bank_req_o   ( bank_req   ),
    .ctrl_req_o   ( ctrl_req   ),
    .tgt_op_o     ( tgt_op     ),
    .tgt_addr_o   ( tgt_addr   ),
    .tgt_wdata_o  ( tgt_wdata  ),
    .tgt_be_o     ( tgt_be     ),
    .bank_rdata_i ( bank_rdata ),
    .ctrl_rdata_i ( ctrl_rdata ),
    .rsp_valid_o,
    .rsp_rdata_o,
    .rsp_err_o,
    .rsp_credit_i
  );

  // Banks see the word index of the in-bank byte offset
  for (genvar i = 0; i < `ISL_NUM_BANKS; i++) begin : gen_bank
    island_sram_bank i_bank (
      .clk_i,
      .rst_ni,
      .req_i   ( bank_req[i]            ),
      .op_i    ( tgt_op                 ),
      .addr_i  ( tgt_addr[WordAw+1:2]   ),
      .wdata_i ( tgt_wdata              ),
      .be_i    ( tgt_be                 ),
      .rdata_o ( bank_rdata[i]          )
    );
  end

  island_soc_ctrl i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .req_i   ( ctrl_req   ),
    .op_i    ( tgt_op     ),
    .addr_i  ( tgt_addr   ),
    .wdata_i ( tgt_wdata  ),
    .rdata_o ( ctrl_rdata ),
    .bootmode_i,
    .fetch_enable_i,
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
island_pkg.sv
island_req_buffer.sv
island_router.sv
island_sram_bank.sv
island_soc_ctrl.sv
island_top.sv
island_asserts.sv
tb_island_top.sv

/* tb_island_top.sv */
// ----------------------------------------------------------
// Testbench for island_top: random and directed traffic checked
// against a memory and register model, random credit return.
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "island_defines.svh"
`default_nettype none

module tb_island_top;
  import island_pkg::*;

  localparam int unsigned BankSpan  = `ISL_NUM_BANKS * `ISL_BANK_BYTES;
  localparam int unsigned NumWords  = BankSpan / 4;
  localparam int unsigned WaitLimit = 2000;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       req_valid_i;
  island_op_e                 req_op_i;
  logic [`ISL_ADDR_WIDTH-1:0] req_addr_i;
  logic [`ISL_DATA_WIDTH-1:0] req_wdata_i;
  logic [`ISL_BE_WIDTH-1:0]   req_be_i;
  logic                       req_credit_o;
  logic                       rsp_valid_o;
  logic [`ISL_DATA_WIDTH-1:0] rsp_rdata_o;
  logic                       rsp_err_o;
  logic                       rsp_credit_i;
  boot_mode_e                 bootmode_i;
  logic                       fetch_enable_i;
  logic                       fetch_enable_o;
  logic [`ISL_DATA_WIDTH-1:0] boot_addr_o;

  // Reference model of banks and control registers
  logic [`ISL_DATA_WIDTH-1:0] mem_model [NumWords];
  logic [`ISL_DATA_WIDTH-1:0] bootaddr_model;
  logic                       fetchen_model;

  logic [`ISL_DATA_WIDTH-1:0] exp_rdata_q [$];
  logic                       exp_err_q   [$];
  logic [`ISL_ADDR_WIDTH-1:0] exp_addr_q  [$];

  logic [31:0] lcg_state;
  logic [31:0] crd_lcg_state;
  int          req_credits;
  int          credits_owed;
  int          max_owed;
  int          hold_cycles;
  int          sent;
  int          credit_pulses;
  int          value_errors;
  int          other_errors;
  bit          timed_out;

  island_top DUT (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  // Upper LCG bits rotated down since the low bits are weak
  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return {state[15:0], state[31:16]};
  endfunction

  function automatic void predict(input island_op_e op, input logic [15:0] addr,
                                  input logic [31:0] wdata, input logic [3:0] be,
                                  output logic [31:0] rdata, output logic err);
    int unsigned word;
    int unsigned off;
    rdata = '0;
    err   = 1'b0;
    if ((addr - `ISL_BANK_BASE) < BankSpan) begin
      word = (addr - `ISL_BANK_BASE) / 4;
      if (op == OP_WRITE) begin
        for (int b = 0; b < `ISL_BE_WIDTH; b++) begin
          if (be[b]) begin
            mem_model[word][b*8 +: 8] = wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata = mem_model[word];
      end
    end else if ((addr - `ISL_CTRL_BASE) < `ISL_CTRL_BYTES) begin
      off = addr - `ISL_CTRL_BASE;
      if (op == OP_WRITE) begin
        if (off == `ISL_REG_BOOTADDR) begin
          bootaddr_model = wdata;
        end else if (off == `ISL_REG_FETCHEN) begin
          fetchen_model = wdata[0];
        end
      end else if (off == `ISL_REG_BOOTADDR) begin
        rdata = bootaddr_model;
      end else if (off == `ISL_REG_FETCHEN) begin
        rdata = {31'b0, fetchen_model};
      end else if (off == `ISL_REG_BOOTMODE) begin
        rdata = 32'(BOOT_JTAG);
      end
    end else begin
      err = 1'b1;
      if (op == OP_READ) begin
        rdata = `ISL_ERR_RDATA;
      end
    end
  endfunction

  task automatic issue(input island_op_e op, input logic [15:0] addr,
                       input logic [31:0] wdata, input logic [3:0] be);
    logic [31:0] rdata;
    logic        err;
    int          waited;
    waited = 0;
    if (timed_out) return;
    while (req_credits == 0) begin
      if (waited == WaitLimit) begin
        $display("Timeout: no request credit came back within %0d cycles", WaitLimit);
        timed_out = 1'b1;
        other_errors++;
        return;
      end
      @(posedge clk_i);
      #1;
      waited++;
    end
    predict(op, addr, wdata, be, rdata, err);
    exp_rdata_q.push_back(rdata);
    exp_err_q.push_back(err);
    exp_addr_q.push_back(addr);
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_be_i    = be;
    req_credits--;
    sent++;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    if (timed_out) return;
    while (exp_rdata_q.size() != 0) begin
      if (waited == WaitLimit) begin
        $display("Timeout: %0d responses still missing", exp_rdata_q.size());
        timed_out = 1'b1;
        other_errors++;
        return;
      end
      @(posedge clk_i);
      #1;
      waited++;
    end
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge clk_i) begin : monitor
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic [15:0] exp_addr;
    if (rst_ni) begin
      if (req_credit_o) begin
        req_credits++;
        credit_pulses++;
      end
      if (req_credits > `ISL_REQ_DEPTH) begin
        $display("More request credits returned than were spent");
        other_errors++;
      end
      if (rsp_valid_o) begin
        credits_owed++;
        if (credits_owed > max_owed) begin
          max_owed = credits_owed;
        end
        if (credits_owed > `ISL_RSP_CREDITS) begin
          $display("Response arrived while all response credits were withheld");
          other_errors++;
        end
        if (exp_rdata_q.size() == 0) begin
          $display("Response arrived with no request waiting for one");
          other_errors++;
        end else begin
          exp_rdata = exp_rdata_q.pop_front();
          exp_err   = exp_err_q.pop_front();
          exp_addr  = exp_addr_q.pop_front();
          if (rsp_rdata_o !== exp_rdata) begin
            $display("** Error rsp_rdata_o: addr %h expected %h, got %h",
                     exp_addr, exp_rdata, rsp_rdata_o);
            value_errors++;
          end
          if (rsp_err_o !== exp_err) begin
            $display("** Error rsp_err_o: addr %h expected %h, got %h",
                     exp_addr, exp_err, rsp_err_o);
            value_errors++;
          end
        end
      end
    end
  end

  // Random credit return with long withholding stretches
  always @(posedge clk_i) begin : return_credits
    logic [31:0] r;
    #1;
    rsp_credit_i = 1'b0;
    if (rst_ni && credits_owed > 0) begin
      r = lcg_next(crd_lcg_state);
      if (hold_cycles > 0) begin
        hold_cycles--;
      end else if (r[7:0] < 8'd6) begin
        hold_cycles = 24 + int'(r[13:8]);
      end else if (r[9]) begin
        rsp_credit_i = 1'b1;
        credits_owed--;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] wdata;
    logic [15:0] addr;
    island_op_e  op;
    lcg_state      = 32'd94;
    crd_lcg_state  = 32'd94;
    req_credits    = `ISL_REQ_DEPTH;
    credits_owed   = 0;
    max_owed       = 0;
    hold_cycles    = 0;
    sent           = 0;
    credit_pulses  = 0;
    value_errors   = 0;
    other_errors   = 0;
    timed_out      = 1'b0;
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_op_i       = OP_READ;
    req_addr_i     = '0;
    req_wdata_i    = '0;
    req_be_i       = '0;
    rsp_credit_i   = 1'b0;
    bootmode_i     = BOOT_JTAG;
    fetch_enable_i = 1'b0;
    bootaddr_model = `ISL_BOOT_ADDR_DEFAULT;
    fetchen_model  = 1'b1;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    if (req_credit_o !== 1'b0 || rsp_valid_o !== 1'b0) begin
      $display("Credit or response output active right after reset");
      other_errors++;
    end

    // Control registers out of reset
    issue(OP_READ, `ISL_CTRL_BASE + `ISL_REG_BOOTADDR, '0, 4'hF);
    issue(OP_READ, `ISL_CTRL_BASE + `ISL_REG_BOOTMODE, '0, 4'hF);
    issue(OP_READ, `ISL_CTRL_BASE + `ISL_REG_FETCHEN, '0, 4'hF);
    issue(OP_READ, `ISL_CTRL_BASE + 16'hC, '0, 4'hF);
    drain();
    if (fetch_enable_o !== 1'b1) begin
      $display("** Error fetch_enable_o: expected %h, got %h", 1'b1, fetch_enable_o);
      value_errors++;
    end
    r = lcg_next(lcg_state);
    issue(OP_WRITE, `ISL_CTRL_BASE + `ISL_REG_BOOTADDR, r, 4'h1);
    issue(OP_WRITE, `ISL_CTRL_BASE + `ISL_REG_BOOTMODE, 32'h3, 4'hF);
    issue(OP_READ, `ISL_CTRL_BASE + `ISL_REG_BOOTADDR, '0, 4'hF);
    issue(OP_READ, `ISL_CTRL_BASE + `ISL_REG_BOOTMODE, '0, 4'hF);
    drain();
    if (boot_addr_o !== bootaddr_model) begin
      $display("** Error boot_addr_o: expected %h, got %h", bootaddr_model, boot_addr_o);
      value_errors++;
    end

    // Fetch enable follows the register, or the pin when it is high
    issue(OP_WRITE, `ISL_CTRL_BASE + `ISL_REG_FETCHEN, 32'h0, 4'hF);
    issue(OP_READ, `ISL_CTRL_BASE + `ISL_REG_FETCHEN, '0, 4'hF);
    drain();
    fetch_enable_i = 1'b1;
    @(negedge clk_i);
    if (fetch_enable_o !== 1'b1) begin
      $display("** Error fetch_enable_o: expected %h, got %h", 1'b1, fetch_enable_o);
      value_errors++;
    end
    @(posedge clk_i);
    #1;
    fetch_enable_i = 1'b0;
    @(negedge clk_i);
    if (fetch_enable_o !== fetchen_model) begin
      $display("** Error fetch_enable_o: expected %h, got %h", fetchen_model, fetch_enable_o);
      value_errors++;
    end
    @(posedge clk_i);
    #1;
    issue(OP_WRITE, `ISL_CTRL_BASE + `ISL_REG_FETCHEN, 32'h1, 4'hF);
    drain();
    if (fetch_enable_o !== 1'b1) begin
      $display("** Error fetch_enable_o: expected %h, got %h", 1'b1, fetch_enable_o);
      value_errors++;
    end

    // Fill both banks with an address pattern
    for (int w = 0; w < NumWords; w++) begin
      addr = 16'(`ISL_BANK_BASE + w * 4);
      issue(OP_WRITE, addr, {addr ^ 16'hA5C3, addr}, 4'hF);
    end

    // Random traffic, now and then to unmapped space
    repeat (600) begin
      r    = lcg_next(lcg_state);
      addr = 16'(`ISL_BANK_BASE + (r % NumWords) * 4);
      op   = r[20] ? OP_WRITE : OP_READ;
      if (r[31:28] == 4'h0) begin
        addr = addr | 16'h4000;
      end
      wdata = lcg_next(lcg_state);
      issue(op, addr, wdata, r[25:22]);
    end

    // Unmapped addresses
    issue(OP_READ, 16'(`ISL_BANK_BASE + BankSpan), '0, 4'hF);
    issue(OP_READ, `ISL_CTRL_BASE + `ISL_CTRL_BYTES, '0, 4'hF);
    issue(OP_WRITE, `ISL_CTRL_BASE + `ISL_CTRL_BYTES, 32'h1234_5678, 4'hF);
    issue(OP_READ, 16'hFFFC, '0, 4'hF);
    repeat (40) begin
      r     = lcg_next(lcg_state);
      wdata = lcg_next(lcg_state);
      issue(r[16] ? OP_WRITE : OP_READ, r[15:0] | 16'h4000, wdata, r[19:16]);
    end
    drain();

    if (!timed_out && credit_pulses != sent) begin
      $display("Request credit pulses (%0d) differ from requests sent (%0d)",
               credit_pulses, sent);
      other_errors++;
    end
    if (!timed_out && max_owed != `ISL_RSP_CREDITS) begin
      $display("Response credits were never fully held back by the manager");
      other_errors++;
    end
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
